// File: rtl/rsa_params.svh
`ifndef RSA_PARAMS_SVH
`define RSA_PARAMS_SVH

`define RSA_WIDTH       32
`define RSA_BUS_WIDTH   (2 * `RSA_WIDTH)

// Command opcodes, low three bits of the command word
`define RSA_OP_EXP      3'd0
`define RSA_OP_MONT     3'd1
`define RSA_OP_LOAD_MOD 3'd2
`define RSA_OP_LOAD_RSQ 3'd3
`define RSA_OP_LOAD_EXP 3'd4
`define RSA_OP_READ     3'd5

`endif

// File: rtl/rsa_pkg.sv
`include "rsa_params.svh"

package rsa_pkg;

    typedef enum logic [2:0] {
        OP_EXP      = `RSA_OP_EXP,
        OP_MONT     = `RSA_OP_MONT,
        OP_LOAD_MOD = `RSA_OP_LOAD_MOD,
        OP_LOAD_RSQ = `RSA_OP_LOAD_RSQ,
        OP_LOAD_EXP = `RSA_OP_LOAD_EXP,
        OP_READ     = `RSA_OP_READ
    } rsa_op_e;

    // Host command word
    typedef struct packed {
        logic [28:0] reserved;
        rsa_op_e     op;
    } rsa_cmd_t;

    // Operands held between loads and compute commands
    typedef struct packed {
        logic [`RSA_WIDTH-1:0] modulus;
        logic [`RSA_WIDTH-1:0] r_mod_m;
        logic [`RSA_WIDTH-1:0] r2_mod_m;
        logic [`RSA_WIDTH-1:0] base;
        logic [`RSA_WIDTH-1:0] exponent;
    } rsa_operands_t;

endpackage

// File: rtl/rsa_mont_mul.sv
`timescale 1ns/100ps
`include "rsa_params.svh"

module rsa_mont_mul (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  mul_start,
    input  logic [`RSA_WIDTH-1:0] a,
    input  logic [`RSA_WIDTH-1:0] b,
    input  logic [`RSA_WIDTH-1:0] m,
    output logic                  mul_done,
    output logic [`RSA_WIDTH-1:0] p
);
    localparam int CNT_W = $clog2(`RSA_WIDTH);
    localparam int ACC_W = `RSA_WIDTH + 2;

    logic [`RSA_WIDTH-1:0] a_sh;
    logic [`RSA_WIDTH-1:0] b_q;
    logic [`RSA_WIDTH-1:0] m_q;
    logic [ACC_W-1:0]      acc;
    logic [ACC_W-1:0]      sum_b;
    logic [ACC_W-1:0]      sum_m;
    logic [ACC_W-1:0]      acc_next;
    logic [ACC_W-1:0]      acc_red;
    logic [CNT_W-1:0]      cnt;
    logic                  busy;
    logic                  last;

    // One radix-2 step, acc stays below 2m
    always_comb begin
        sum_b    = acc + (a_sh[0] ? {2'b00, b_q} : '0);
        sum_m    = sum_b + (sum_b[0] ? {2'b00, m_q} : '0);
        acc_next = sum_m >> 1;
        acc_red  = (acc_next >= {2'b00, m_q}) ? acc_next - {2'b00, m_q} : acc_next;
    end

    assign last = (cnt == CNT_W'(`RSA_WIDTH - 1));

    always_ff @(posedge clk) begin
        if (!resetn) begin
            busy     <= 1'b0;
            cnt      <= '0;
            mul_done <= 1'b0;
        end else begin
            mul_done <= 1'b0;
            if (mul_start) begin
                busy <= 1'b1;
                cnt  <= '0;
            end else if (busy) begin
                cnt <= cnt + 1'b1;
                if (last) begin
                    busy     <= 1'b0;
                    mul_done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mul_start) begin
            a_sh <= a;
            b_q  <= b;
            m_q  <= m;
            acc  <= '0;
        end else if (busy) begin
            a_sh <= a_sh >> 1;
            acc  <= acc_next;
            if (last) p <= acc_red[`RSA_WIDTH-1:0];
        end
    end

endmodule

// File: rtl/rsa_mod_exp.sv
`timescale 1ns/100ps
`include "rsa_params.svh"

module rsa_mod_exp (
    input  logic                   clk,
    input  logic                   resetn,
    input  rsa_pkg::rsa_operands_t operands,
    input  logic                   start,
    input  logic                   mont_only,
    output logic                   exp_done,
    output logic [`RSA_WIDTH-1:0]  exp_result
);
    localparam int IDX_W = $clog2(`RSA_WIDTH);
    localparam logic [`RSA_WIDTH-1:0] ONE = 1;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_CONV,
        ST_SQR,
        ST_MUL,
        ST_OUT
    } state_e;

    state_e                state;
    logic                  mul_start;
    logic                  mul_done;
    logic [`RSA_WIDTH-1:0] mul_a;
    logic [`RSA_WIDTH-1:0] mul_b;
    logic [`RSA_WIDTH-1:0] mul_p;
    logic [`RSA_WIDTH-1:0] base_m;
    logic [IDX_W-1:0]      idx;
    logic                  last_bit;

    assign last_bit = (idx == '0);

    rsa_mont_mul u_mul (
        .clk      (clk),
        .resetn   (resetn),
        .mul_start(mul_start),
        .a        (mul_a),
        .b        (mul_b),
        .m        (operands.modulus),
        .mul_done (mul_done),
        .p        (mul_p)
    );

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state     <= ST_IDLE;
            mul_start <= 1'b0;
            exp_done  <= 1'b0;
            idx       <= '0;
        end else begin
            mul_start <= 1'b0;
            exp_done  <= 1'b0;
            case (state)
                ST_IDLE: begin
                    // Both paths begin with base times R^2 mod m
                    if (start) begin
                        mul_a     <= operands.base;
                        mul_b     <= operands.r2_mod_m;
                        mul_start <= 1'b1;
                        state     <= mont_only ? ST_OUT : ST_CONV;
                    end
                end
                ST_CONV: begin
                    if (mul_done) begin
                        base_m    <= mul_p;
                        mul_a     <= operands.r_mod_m;
                        mul_b     <= operands.r_mod_m;
                        mul_start <= 1'b1;
                        idx       <= IDX_W'(`RSA_WIDTH - 1);
                        state     <= ST_SQR;
                    end
                end
                ST_SQR, ST_MUL: begin
                    if (mul_done) begin
                        mul_start <= 1'b1;
                        mul_a     <= mul_p;
                        if (state == ST_SQR && operands.exponent[idx]) begin
                            mul_b <= base_m;
                            state <= ST_MUL;
                        end else begin
                            // Last bit done, multiply by 1 to leave the domain
                            mul_b <= last_bit ? ONE : mul_p;
                            state <= last_bit ? ST_OUT : ST_SQR;
                            idx   <= idx - 1'b1;
                        end
                    end
                end
                ST_OUT: begin
                    if (mul_done) begin
                        exp_result <= mul_p;
                        exp_done   <= 1'b1;
                        state      <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

// File: rtl/rsa_cmd_decode.sv
`timescale 1ns/100ps
`include "rsa_params.svh"

module rsa_cmd_decode (
    input  logic                      clk,
    input  logic                      resetn,
    input  logic                      cmd_valid,
    input  rsa_pkg::rsa_cmd_t         cmd,
    output logic                      done,
    input  logic                      done_read,
    input  logic                      in_data_valid,
    output logic                      in_data_ready,
    input  logic [`RSA_BUS_WIDTH-1:0] in_data,
    output rsa_pkg::rsa_operands_t    operands,
    output logic                      start,
    output logic                      mont_only,
    input  logic                      exp_done,
    output logic                      send_req,
    input  logic                      sent
);
    import rsa_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOAD,
        ST_COMPUTE,
        ST_SEND,
        ST_DONE
    } state_e;

    state_e  state;
    rsa_op_e op_q;
    logic    in_xfer;

    assign in_data_ready = (state == ST_LOAD);
    assign done          = (state == ST_DONE);
    assign in_xfer       = in_data_valid && in_data_ready;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state     <= ST_IDLE;
            op_q      <= OP_EXP;
            start     <= 1'b0;
            send_req  <= 1'b0;
            mont_only <= 1'b0;
        end else begin
            start    <= 1'b0;
            send_req <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (cmd_valid) begin
                        op_q <= cmd.op;
                        case (cmd.op)
                            OP_LOAD_MOD, OP_LOAD_RSQ, OP_LOAD_EXP: begin
                                state <= ST_LOAD;
                            end
                            OP_EXP, OP_MONT: begin
                                state     <= ST_COMPUTE;
                                start     <= 1'b1;
                                mont_only <= (cmd.op == OP_MONT);
                            end
                            OP_READ: begin
                                state    <= ST_SEND;
                                send_req <= 1'b1;
                            end
                            // Unknown opcodes leave the FSM idle
                            default: state <= ST_IDLE;
                        endcase
                    end
                end
                ST_LOAD:    if (in_xfer) state <= ST_DONE;
                ST_COMPUTE: if (exp_done) state <= ST_DONE;
                ST_SEND:    if (sent) state <= ST_DONE;
                ST_DONE:    if (done_read) state <= ST_IDLE;
                default:    state <= ST_IDLE;
            endcase
        end
    end

    // Second operand of a load word sits in the high half
    always_ff @(posedge clk) begin
        if (in_xfer) begin
            case (op_q)
                OP_LOAD_MOD: begin
                    operands.modulus <= in_data[`RSA_WIDTH-1:0];
                    operands.r_mod_m <= in_data[`RSA_BUS_WIDTH-1:`RSA_WIDTH];
                end
                OP_LOAD_RSQ: begin
                    operands.r2_mod_m <= in_data[`RSA_WIDTH-1:0];
                    operands.base     <= in_data[`RSA_BUS_WIDTH-1:`RSA_WIDTH];
                end
                OP_LOAD_EXP: begin
                    operands.exponent <= in_data[`RSA_WIDTH-1:0];
                end
                default: begin
                    operands <= operands;
                end
            endcase
        end
    end

endmodule

// File: rtl/rsa_result.sv
`timescale 1ns/100ps
`include "rsa_params.svh"

module rsa_result (
    input  logic                      clk,
    input  logic                      resetn,
    input  logic                      exp_done,
    input  logic [`RSA_WIDTH-1:0]     exp_result,
    input  logic                      send_req,
    output logic                      sent,
    output logic                      out_data_valid,
    input  logic                      out_data_ready,
    output logic [`RSA_BUS_WIDTH-1:0] out_data
);
    logic [`RSA_WIDTH-1:0] result_q;

    // Kept until the next compute, so reads can repeat
    always_ff @(posedge clk) begin
        if (exp_done) result_q <= exp_result;
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            out_data_valid <= 1'b0;
        end else if (send_req) begin
            out_data_valid <= 1'b1;
        end else if (sent) begin
            out_data_valid <= 1'b0;
        end
    end

    assign sent     = out_data_valid && out_data_ready;
    assign out_data = {{(`RSA_BUS_WIDTH - `RSA_WIDTH){1'b0}}, result_q};

endmodule

// File: rtl/rsa_accel_top.sv
`timescale 1ns/100ps
`include "rsa_params.svh"

module rsa_accel_top (
    input  logic                      clk,
    input  logic                      resetn,
    input  logic                      cmd_valid,
    input  rsa_pkg::rsa_cmd_t         cmd,
    output logic                      done,
    input  logic                      done_read,
    input  logic                      in_data_valid,
    output logic                      in_data_ready,
    input  logic [`RSA_BUS_WIDTH-1:0] in_data,
    output logic                      out_data_valid,
    input  logic                      out_data_ready,
    output logic [`RSA_BUS_WIDTH-1:0] out_data
);
    import rsa_pkg::*;

    rsa_operands_t         operands;
    logic                  start;
    logic                  mont_only;
    logic                  exp_done;
    logic [`RSA_WIDTH-1:0] exp_result;
    logic                  send_req;
    logic                  sent;

    rsa_cmd_decode u_decode (
        .clk          (clk),
        .resetn       (resetn),
        .cmd_valid    (cmd_valid),
        .cmd          (cmd),
        .done         (done),
        .done_read    (done_read),
        .in_data_valid(in_data_valid),
        .in_data_ready(in_data_ready),
        .in_data      (in_data),
        .operands     (operands),
        .start        (start),
        .mont_only    (mont_only),
        .exp_done     (exp_done),
        .send_req     (send_req),
        .sent         (sent)
    );

    rsa_mod_exp u_exp (
        .clk       (clk),
        .resetn    (resetn),
        .operands  (operands),
        .start     (start),
        .mont_only (mont_only),
        .exp_done  (exp_done),
        .exp_result(exp_result)
    );

    rsa_result u_result (
        .clk           (clk),
        .resetn        (resetn),
        .exp_done      (exp_done),
        .exp_result    (exp_result),
        .send_req      (send_req),
        .sent          (sent),
        .out_data_valid(out_data_valid),
        .out_data_ready(out_data_ready),
        .out_data      (out_data)
    );

endmodule

// File: verification/tb_rsa_tasks.svh
`ifndef TB_RSA_TASKS_SVH
`define TB_RSA_TASKS_SVH

// Reference arithmetic on double-width words, R = 2^RSA_WIDTH
function automatic logic [`RSA_WIDTH-1:0] r_mod(input logic [`RSA_WIDTH-1:0] m);
    logic [`RSA_BUS_WIDTH-1:0] m_ext;
    logic [`RSA_BUS_WIDTH-1:0] r;
    m_ext = m;
    r     = (64'd1 << `RSA_WIDTH) % m_ext;
    return r[`RSA_WIDTH-1:0];
endfunction

function automatic logic [`RSA_WIDTH-1:0] r2_mod(input logic [`RSA_WIDTH-1:0] m);
    logic [`RSA_BUS_WIDTH-1:0] m_ext;
    logic [`RSA_BUS_WIDTH-1:0] rm;
    logic [`RSA_BUS_WIDTH-1:0] r2;
    m_ext = m;
    rm    = r_mod(m);
    r2    = (rm * rm) % m_ext;
    return r2[`RSA_WIDTH-1:0];
endfunction

function automatic logic [`RSA_WIDTH-1:0] pow_mod(input logic [`RSA_WIDTH-1:0] b,
                                                  input logic [`RSA_WIDTH-1:0] e,
                                                  input logic [`RSA_WIDTH-1:0] m);
    logic [`RSA_BUS_WIDTH-1:0] m_ext;
    logic [`RSA_BUS_WIDTH-1:0] b_ext;
    logic [`RSA_BUS_WIDTH-1:0] acc;
    m_ext = m;
    b_ext = b;
    acc   = 64'd1 % m_ext;
    b_ext = b_ext % m_ext;
    for (int i = `RSA_WIDTH - 1; i >= 0; i--) begin
        acc = (acc * acc) % m_ext;
        if (e[i]) acc = (acc * b_ext) % m_ext;
    end
    return acc[`RSA_WIDTH-1:0];
endfunction

function automatic logic [`RSA_WIDTH-1:0] expected_of(input rsa_op_e op,
                                                      input logic [`RSA_WIDTH-1:0] b,
                                                      input logic [`RSA_WIDTH-1:0] e,
                                                      input logic [`RSA_WIDTH-1:0] m);
    logic [`RSA_BUS_WIDTH-1:0] m_ext;
    logic [`RSA_BUS_WIDTH-1:0] conv;
    m_ext = m;
    conv  = {b, {`RSA_WIDTH{1'b0}}} % m_ext;
    return (op == OP_MONT) ? conv[`RSA_WIDTH-1:0] : pow_mod(b, e, m);
endfunction

task automatic check_result(input rsa_op_e op, input string name,
                            input logic [`RSA_BUS_WIDTH-1:0] got,
                            input logic [`RSA_BUS_WIDTH-1:0] expected);
    if (got !== expected) begin
        errors++;
        $display("Fail at %0t ns: %s after %s got %h expected %h",
                 $time, name, op.name(), got, expected);
    end
endtask

task automatic check_flag(input string name, input logic got, input logic expected);
    if (got !== expected) begin
        errors++;
        $display("Fail at %0t ns: %s got %b expected %b", $time, name, got, expected);
    end
endtask

task automatic send_command(input rsa_cmd_t c);
    cmd       = c;
    cmd_valid = 1'b1;
    @(negedge clk);
    cmd_valid = 1'b0;
    cmd       = '0;
endtask

// Waits for done, holds done_read low for a while, then acknowledges
task automatic finish_command();
    int hold;
    while (!done) @(negedge clk);
    hold = $unsigned($random(seed)) % 5;
    repeat (hold) begin
        @(negedge clk);
        check_flag("done while done_read low", done, 1'b1);
    end
    done_read = 1'b1;
    @(negedge clk);
    done_read = 1'b0;
    check_flag("done after done_read", done, 1'b0);
endtask

task automatic load_word(input rsa_op_e op, input logic [`RSA_BUS_WIDTH-1:0] word);
    send_command('{reserved: '0, op: op});
    check_flag("in_data_ready after load command", in_data_ready, 1'b1);
    in_data       = word;
    in_data_valid = 1'b1;
    @(negedge clk);
    in_data_valid = 1'b0;
    check_flag("done after load transfer", done, 1'b1);
    finish_command();
endtask

task automatic run_compute(input rsa_op_e op);
    send_command('{reserved: '0, op: op});
    finish_command();
endtask

task automatic read_result(output logic [`RSA_BUS_WIDTH-1:0] word);
    logic [`RSA_BUS_WIDTH-1:0] held;
    int                        hold;
    send_command('{reserved: '0, op: OP_READ});
    while (!out_data_valid) @(negedge clk);
    held = out_data;
    hold = 1 + $unsigned($random(seed)) % 4;
    repeat (hold) begin
        @(negedge clk);
        check_flag("out_data_valid under back-pressure", out_data_valid, 1'b1);
        check_result(OP_READ, "out_data under back-pressure", out_data, held);
    end
    out_data_ready = 1'b1;
    word           = out_data;
    @(negedge clk);
    out_data_ready = 1'b0;
    check_flag("out_data_valid after transfer", out_data_valid, 1'b0);
    finish_command();
endtask

task automatic check_unknown_op(input logic [2:0] opcode);
    send_command(rsa_cmd_t'({29'd0, opcode}));
    repeat (20) begin
        check_flag("done after unknown opcode", done, 1'b0);
        check_flag("in_data_ready after unknown opcode", in_data_ready, 1'b0);
        @(negedge clk);
    end
endtask

`endif

// File: verification/tb_rsa_accel.sv
`timescale 1ns/100ps
`include "rsa_params.svh"

module tb_rsa_accel;
    import rsa_pkg::*;

    localparam int NUM_FIXED  = 7;
    localparam int NUM_RANDOM = 6;
    localparam int NUM_TESTS  = NUM_FIXED + NUM_RANDOM;
    // Worst entry is EXP with all exponent bits set, plus loads, reads and handshakes
    localparam int MULS_PER_TEST   = 2 * `RSA_WIDTH + 3;
    localparam int CYCLES_PER_TEST = MULS_PER_TEST * (`RSA_WIDTH + 4) + 300;
    localparam int TIMEOUT_CYCLES  = NUM_TESTS * CYCLES_PER_TEST + 200;

    typedef struct packed {
        logic [`RSA_WIDTH-1:0] modulus;
        logic [`RSA_WIDTH-1:0] base;
        logic [`RSA_WIDTH-1:0] exponent;
        rsa_op_e               op;
        logic [`RSA_WIDTH-1:0] expected;
    } test_entry_t;

    logic                      clk = 1'b0;
    logic                      resetn;
    logic                      cmd_valid;
    rsa_cmd_t                  cmd;
    logic                      done;
    logic                      done_read;
    logic                      in_data_valid;
    logic                      in_data_ready;
    logic [`RSA_BUS_WIDTH-1:0] in_data;
    logic                      out_data_valid;
    logic                      out_data_ready;
    logic [`RSA_BUS_WIDTH-1:0] out_data;

    test_entry_t tests [NUM_TESTS];
    integer      seed = 32'ha647;
    int          errors;
    int          passed;
    int          cycle_count;

    rsa_accel_top u_dut (
        .clk           (clk),
        .resetn        (resetn),
        .cmd_valid     (cmd_valid),
        .cmd           (cmd),
        .done          (done),
        .done_read     (done_read),
        .in_data_valid (in_data_valid),
        .in_data_ready (in_data_ready),
        .in_data       (in_data),
        .out_data_valid(out_data_valid),
        .out_data_ready(out_data_ready),
        .out_data      (out_data)
    );

    `include "tb_rsa_tasks.svh"

    always #2 clk = ~clk;

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the DUT did not finish the tests within %0d cycles", TIMEOUT_CYCLES);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        test_entry_t               t;
        logic [`RSA_WIDTH-1:0]     m;
        logic [`RSA_BUS_WIDTH-1:0] got;
        logic [`RSA_BUS_WIDTH-1:0] expected;
        int                        err_before;

        resetn         = 1'b0;
        cmd_valid      = 1'b0;
        cmd            = '0;
        done_read      = 1'b0;
        in_data_valid  = 1'b0;
        in_data        = '0;
        out_data_ready = 1'b0;
        errors         = 0;
        passed         = 0;

        // modulus, base, exponent, op, expected result
        tests[0] = '{32'd3233, 32'd65, 32'd17, OP_EXP, 32'd2790};
        tests[1] = '{32'd3233, 32'd2790, 32'd2753, OP_EXP, 32'd65};
        tests[2] = '{32'h7fff_ffff, 32'd12345, 32'd0, OP_EXP, 32'd1};
        tests[3] = '{32'h7fff_ffff, 32'h0123_4567, 32'd1, OP_EXP, 32'h0123_4567};
        tests[4] = '{32'h7fff_ffed, 32'h7fff_ffec, 32'hffff_ffff, OP_EXP, 32'h7fff_ffec};
        tests[5] = '{32'h7fff_ffff, 32'd12345, 32'd0, OP_MONT, 32'd24690};
        tests[6] = '{32'd3, 32'd2, 32'hffff_ffff, OP_EXP, 32'd2};
        for (int i = NUM_FIXED; i < NUM_TESTS; i++) begin
            m = ($random(seed) & 32'h7fff_ffff) | 32'd1;
            if (m < 32'd3) m = 32'd3;
            tests[i].modulus  = m;
            tests[i].base     = $unsigned($random(seed)) % m;
            tests[i].exponent = $random(seed);
            tests[i].op       = (($random(seed) & 3) == 0) ? OP_MONT : OP_EXP;
            tests[i].expected = expected_of(tests[i].op, tests[i].base,
                                            tests[i].exponent, m);
        end

        repeat (10) @(negedge clk);
        resetn = 1'b1;
        @(negedge clk);

        err_before = errors;
        check_flag("done after reset", done, 1'b0);
        check_flag("in_data_ready after reset", in_data_ready, 1'b0);
        check_flag("out_data_valid after reset", out_data_valid, 1'b0);
        check_unknown_op(3'd6);
        check_unknown_op(3'd7);
        if (errors == err_before) passed++;
        $display("Test 0 reset and unknown opcodes: %s", (errors == err_before) ? "ok" : "FAILED");

        for (int i = 0; i < NUM_TESTS; i++) begin
            t          = tests[i];
            err_before = errors;
            expected   = {{`RSA_WIDTH{1'b0}}, t.expected};
            load_word(OP_LOAD_MOD, {r_mod(t.modulus), t.modulus});
            load_word(OP_LOAD_RSQ, {t.base, r2_mod(t.modulus)});
            load_word(OP_LOAD_EXP, {{`RSA_WIDTH{1'b0}}, t.exponent});
            run_compute(t.op);
            read_result(got);
            check_result(t.op, "out_data", got, expected);
            read_result(got);
            check_result(OP_READ, "out_data on second read", got, expected);
            // A new modulus alone must not touch the stored result
            load_word(OP_LOAD_MOD, {r_mod(t.modulus ^ 32'd2), t.modulus ^ 32'd2});
            read_result(got);
            check_result(OP_LOAD_MOD, "out_data after new modulus", got, expected);
            if (errors == err_before) passed++;
            $display("Test %0d %s m=%h base=%h exp=%h: %s", i + 1, t.op.name(), t.modulus,
                     t.base, t.exponent, (errors == err_before) ? "ok" : "FAILED");
        end

        $display("Tests run: %0d, passed: %0d, failed: %0d, check errors: %0d",
                 NUM_TESTS + 1, passed, NUM_TESTS + 1 - passed, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: all.f
+incdir+rtl
+incdir+verification
rtl/rsa_pkg.sv
rtl/rsa_mont_mul.sv
rtl/rsa_mod_exp.sv
rtl/rsa_cmd_decode.sv
rtl/rsa_result.sv
rtl/rsa_accel_top.sv
verification/tb_rsa_accel.sv

// File: Makefile
.PHONY: all lint clean

all:
	verilator --binary --timing -Wno-fatal -f all.f --top-module tb_rsa_accel
	./obj_dir/Vtb_rsa_accel > sim.log 2>&1; cat sim.log
	grep -q "Testbench passed" sim.log

lint:
	verilator --lint-only --timing -Wall -f all.f --top-module tb_rsa_accel

clean:
	rm -rf obj_dir sim.log
